// ==== include/riscv_if_macros.svh ====
`ifndef RISCV_IF_MACROS_SVH
`define RISCV_IF_MACROS_SVH

// Integer register and address width of the core
`define XLEN 32

// Instruction cache is word addressed
// The cache address is the byte pc with the two low bits removed
`define ICACHE_AW 30

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== hw/rv_isa_pkg.sv ====
`include "riscv_if_macros.svh"

package rv_isa_pkg;

    // Full-width instruction and byte address
    typedef logic [`XLEN-1:0] rv_inst_t;
    typedef logic [`XLEN-1:0] rv_addr_t;

    // Compressed instruction, one half-word
    typedef logic [15:0] rv_cinst_t;

    // Major opcodes of the base ISA
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] LOAD   = 7'b0000011;
    localparam logic [6:0] STORE  = 7'b0100011;
    localparam logic [6:0] OP     = 7'b0110011;
    localparam logic [6:0] JAL    = 7'b1101111;
    localparam logic [6:0] BRANCH = 7'b1100011;

    // Base funct3 / funct7 values used by the expansions
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_WORD = 3'b010;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [6:0] F7_ADD  = 7'b0000000;

    // addi x0, x0, 0
    localparam rv_inst_t NOP_INST = {12'd0, 5'd0, F3_ADD, 5'd0, OP_IMM};

    // Compressed quadrants, bits 1:0
    // Quadrant 3 means a 32-bit instruction
    localparam logic [1:0] C_Q0 = 2'b00;
    localparam logic [1:0] C_Q1 = 2'b01;
    localparam logic [1:0] C_Q2 = 2'b10;

    // Compressed funct3, bits 15:13
    localparam logic [2:0] C0_LW     = 3'b010;
    localparam logic [2:0] C0_SW     = 3'b110;
    localparam logic [2:0] C1_ADDI   = 3'b000;
    localparam logic [2:0] C1_LI     = 3'b010;
    localparam logic [2:0] C1_J      = 3'b101;
    localparam logic [2:0] C1_BEQZ   = 3'b110;
    localparam logic [2:0] C2_MV_ADD = 3'b100;

endpackage

// ==== hw/fetch_pkg.sv ====
`include "riscv_if_macros.svh"

package fetch_pkg;

    // Next-pc source chosen by the later stages
    // Bit 0 flags a jump and bit 1 a taken branch
    typedef enum logic [1:0] {
        PC_SEQ    = 2'b00,
        PC_JUMP   = 2'b01,
        PC_BRANCH = 2'b10,
        PC_HOLD   = 2'b11
    } pc_src_e;

    // Word address into the instruction cache
    typedef logic [`ICACHE_AW-1:0] icache_addr_t;

endpackage

// ==== hw/fetch_ctrl.sv ====
`timescale 1ns/100ps
`include "riscv_if_macros.svh"

module fetch_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  logic                 flush,
    input  logic                 load_use_hazard,
    input  fetch_pkg::pc_src_e   pc_src,
    input  rv_isa_pkg::rv_addr_t pc_branch,
    input  rv_isa_pkg::rv_addr_t pc_j,
    input  logic                 inst_ready,
    input  logic                 inst_compressed,
    input  rv_isa_pkg::rv_inst_t inst_aligned,
    input  rv_isa_pkg::rv_inst_t inst_expanded,
    output rv_isa_pkg::rv_addr_t pc,
    output rv_isa_pkg::rv_addr_t pc_ppl,
    output rv_isa_pkg::rv_inst_t inst_ppl,
    output logic                 compressed_ppl
);
    import rv_isa_pkg::*;
    import fetch_pkg::*;

    rv_addr_t pc_next;
    rv_addr_t pc_step;
    rv_inst_t inst_sel;
    logic     pc_advance;

    // Decode always sees a 32-bit encoding
    assign inst_sel = inst_compressed ? inst_expanded : inst_aligned;

    assign pc_step    = pc + (inst_compressed ? 32'd2 : 32'd4);
    assign pc_advance = inst_ready && !stall && !load_use_hazard;

    // Redirects win over back-pressure
    always_comb begin
        case (pc_src)
            PC_JUMP:   pc_next = pc_j;
            PC_BRANCH: pc_next = pc_branch;
            PC_HOLD:   pc_next = pc;
            default:   pc_next = pc_advance ? pc_step : pc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // IF/ID registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_ppl         <= '0;
            inst_ppl       <= '0;
            compressed_ppl <= 1'b0;
        end else if (!stall) begin
            pc_ppl <= pc;
            if (flush || !inst_ready) begin
                // Bubble while the realigner or cache is not done
                inst_ppl       <= NOP_INST;
                compressed_ppl <= 1'b0;
            end else begin
                inst_ppl       <= inst_sel;
                compressed_ppl <= inst_compressed;
            end
        end
    end

endmodule

// ==== hw/realigner.sv ====
`timescale 1ns/100ps
`include "riscv_if_macros.svh"

module realigner (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_isa_pkg::rv_addr_t   pc,
    input  logic                   icache_stall,
    input  rv_isa_pkg::rv_inst_t   icache_rdata,
    output logic                   icache_ren,
    output logic                   icache_wen,
    output fetch_pkg::icache_addr_t icache_addr,
    output rv_isa_pkg::rv_inst_t   icache_wdata,
    output logic                   inst_ready,
    output logic                   inst_compressed,
    output rv_isa_pkg::rv_inst_t   inst_aligned
);
    import rv_isa_pkg::*;
    import fetch_pkg::*;

    icache_addr_t pc_word;
    logic         pc_upper;

    // Carry buffer holds the upper half of word buf_tag
    rv_cinst_t    buf_half;
    icache_addr_t buf_tag;
    logic         buf_valid;

    logic         buf_hit;
    logic         buf_compressed;
    logic         word_ok;
    rv_cinst_t    rdata_lo;
    rv_cinst_t    rdata_hi;

    assign pc_word  = pc[`XLEN-1:2];
    assign pc_upper = pc[1];

    // Half at pc already sits in the buffer
    assign buf_hit        = buf_valid && pc_upper && (buf_tag == pc_word);
    assign buf_compressed = buf_half[1:0] != 2'b11;

    // A buffered compressed half needs no cache access at all
    assign icache_ren  = !(buf_hit && buf_compressed);
    // Second half of a crossing instruction comes from the next word
    assign icache_addr = buf_hit ? pc_word + 1'b1 : pc_word;

    // Fetch never writes the cache
    assign icache_wen   = 1'b0;
    assign icache_wdata = '0;

    assign word_ok  = icache_ren && !icache_stall;
    assign rdata_lo = icache_rdata[15:0];
    assign rdata_hi = icache_rdata[31:16];

    always_comb begin
        if (buf_hit) begin
            inst_compressed = buf_compressed;
            if (buf_compressed) begin
                inst_aligned = {16'h0000, buf_half};
                inst_ready   = 1'b1;
            end else begin
                // Low half from the buffer, high half from word n+1
                inst_aligned = {rdata_lo, buf_half};
                inst_ready   = word_ok;
            end
        end else if (pc_upper) begin
            // Only a compressed upper half completes from one read
            inst_compressed = rdata_hi[1:0] != 2'b11;
            inst_aligned    = {16'h0000, rdata_hi};
            inst_ready      = word_ok && inst_compressed;
        end else begin
            inst_compressed = rdata_lo[1:0] != 2'b11;
            inst_aligned    = icache_rdata;
            inst_ready      = word_ok;
        end
    end

    // Buffer is left alone while it feeds the current instruction,
    // so a held pc keeps hitting it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buf_valid <= 1'b0;
        end else if (word_ok && !buf_hit) begin
            buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (word_ok && !buf_hit) begin
            buf_half <= rdata_hi;
            buf_tag  <= pc_word;
        end
    end

endmodule

// ==== hw/rvc_decompressor.sv ====
`timescale 1ns/100ps
`include "riscv_if_macros.svh"

module rvc_decompressor (
    input  rv_isa_pkg::rv_cinst_t inst_c,
    output rv_isa_pkg::rv_inst_t  inst_expanded
);
    import rv_isa_pkg::*;

    logic [1:0]  quadrant;
    logic [2:0]  funct3;

    // Full register fields
    logic [4:0]  rd_rs1;
    logic [4:0]  rs2;
    logic [4:0]  rs1_sel;

    // Prime registers x8 to x15
    logic [4:0]  rs1_p;
    logic [4:0]  rd_p;

    // Immediates already placed at their 32-bit bit positions
    logic [11:0] ci_imm;
    logic [11:0] w_off;
    logic [20:0] j_off;
    logic [12:0] b_off;

    assign quadrant = inst_c[1:0];
    assign funct3   = inst_c[15:13];

    assign rd_rs1 = inst_c[11:7];
    assign rs2    = inst_c[6:2];
    // C.ADD adds to rd, C.MV adds to x0
    assign rs1_sel = inst_c[12] ? rd_rs1 : 5'd0;

    assign rs1_p = {2'b01, inst_c[9:7]};
    assign rd_p  = {2'b01, inst_c[4:2]};

    // Sign-extended 6-bit immediate of C.ADDI / C.LI
    assign ci_imm = {{6{inst_c[12]}}, inst_c[12], inst_c[6:2]};

    // Word offset, zero-extended and scaled by 4
    assign w_off = {5'd0, inst_c[5], inst_c[12:10], inst_c[6], 2'b00};

    // C.J offset[11|4|9:8|10|6|7|3:1|5]
    assign j_off = {{9{inst_c[12]}}, inst_c[12], inst_c[8], inst_c[10:9],
                    inst_c[6], inst_c[7], inst_c[2], inst_c[11], inst_c[5:3], 1'b0};

    // C.BEQZ offset[8|4:3] and [7:6|2:1|5]
    assign b_off = {{4{inst_c[12]}}, inst_c[12], inst_c[6:5], inst_c[2],
                    inst_c[11:10], inst_c[4:3], 1'b0};

    always_comb begin
        inst_expanded = '0;
        case (quadrant)
            C_Q0: begin
                case (funct3)
                    C0_LW: begin
                        inst_expanded = {w_off, rs1_p, F3_WORD, rd_p, LOAD};
                    end
                    C0_SW: begin
                        // rd_p holds rs2' here
                        inst_expanded = {w_off[11:5], rd_p, rs1_p, F3_WORD,
                                         w_off[4:0], STORE};
                    end
                    default: inst_expanded = '0;
                endcase
            end
            C_Q1: begin
                case (funct3)
                    C1_ADDI: begin
                        // Also covers C.NOP with rd = x0
                        inst_expanded = {ci_imm, rd_rs1, F3_ADD, rd_rs1, OP_IMM};
                    end
                    C1_LI: begin
                        inst_expanded = {ci_imm, 5'd0, F3_ADD, rd_rs1, OP_IMM};
                    end
                    C1_J: begin
                        inst_expanded = {j_off[20], j_off[10:1], j_off[11],
                                         j_off[19:12], 5'd0, JAL};
                    end
                    C1_BEQZ: begin
                        inst_expanded = {b_off[12], b_off[10:5], 5'd0, rs1_p, F3_BEQ,
                                         b_off[4:1], b_off[11], BRANCH};
                    end
                    default: inst_expanded = '0;
                endcase
            end
            C_Q2: begin
                // rs2 of zero is C.JR / C.JALR / C.EBREAK, not supported
                if (funct3 == C2_MV_ADD && rs2 != 5'd0) begin
                    inst_expanded = {F7_ADD, rs2, rs1_sel, F3_ADD, rd_rs1, OP};
                end
            end
            default: inst_expanded = '0;
        endcase
    end

endmodule

// ==== hw/riscv_if.sv ====
`timescale 1ns/100ps
`include "riscv_if_macros.svh"

module riscv_if (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    load_use_hazard,
    input  fetch_pkg::pc_src_e      pc_src,
    input  rv_isa_pkg::rv_addr_t    pc_branch,
    input  rv_isa_pkg::rv_addr_t    pc_j,
    input  logic                    icache_stall,
    input  rv_isa_pkg::rv_inst_t    icache_rdata,
    output logic                    icache_ren,
    output logic                    icache_wen,
    output fetch_pkg::icache_addr_t icache_addr,
    output rv_isa_pkg::rv_inst_t    icache_wdata,
    output rv_isa_pkg::rv_inst_t    inst_ppl,
    output rv_isa_pkg::rv_addr_t    pc_ppl,
    output logic                    compressed_ppl,
    output rv_isa_pkg::rv_addr_t    pc
);
    import rv_isa_pkg::*;

    logic     inst_ready;
    logic     inst_compressed;
    rv_inst_t inst_aligned;
    rv_inst_t inst_expanded;

    fetch_ctrl u_fetch_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall           (stall),
        .flush           (flush),
        .load_use_hazard (load_use_hazard),
        .pc_src          (pc_src),
        .pc_branch       (pc_branch),
        .pc_j            (pc_j),
        .inst_ready      (inst_ready),
        .inst_compressed (inst_compressed),
        .inst_aligned    (inst_aligned),
        .inst_expanded   (inst_expanded),
        .pc              (pc),
        .pc_ppl          (pc_ppl),
        .inst_ppl        (inst_ppl),
        .compressed_ppl  (compressed_ppl)
    );

    realigner u_realigner (
        .clk             (clk),
        .rst_n           (rst_n),
        .pc              (pc),
        .icache_stall    (icache_stall),
        .icache_rdata    (icache_rdata),
        .icache_ren      (icache_ren),
        .icache_wen      (icache_wen),
        .icache_addr     (icache_addr),
        .icache_wdata    (icache_wdata),
        .inst_ready      (inst_ready),
        .inst_compressed (inst_compressed),
        .inst_aligned    (inst_aligned)
    );

    // Expansion only looks at the low half
    rvc_decompressor u_rvc_decompressor (
        .inst_c        (inst_aligned[15:0]),
        .inst_expanded (inst_expanded)
    );

endmodule

// ==== test/riscv_if_sva.sv ====
`timescale 1ns/100ps
`include "riscv_if_macros.svh"

module riscv_if_sva (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 stall,
    input logic                 icache_wen,
    input rv_isa_pkg::rv_inst_t inst_ppl,
    input rv_isa_pkg::rv_addr_t pc_ppl,
    input logic                 compressed_ppl,
    input rv_isa_pkg::rv_addr_t pc
);
    import rv_isa_pkg::*;
    import fetch_pkg::*;

    // Number of failed assertions
    int unsigned error_count = 0;

    // Fetch has no store path
    wen_low: assert property (@(posedge clk) !icache_wen)
        else begin
            $error("icache_wen went high");
            error_count++;
        end

    // Compressed instructions sit on half-word boundaries
    comp_align: assert property (@(posedge clk) disable iff (!rst_n)
        compressed_ppl |-> !pc_ppl[0])
        else begin
            $error("compressed instruction at odd byte address %h", pc_ppl);
            error_count++;
        end

    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(inst_ppl) && $stable(pc_ppl))
        else begin
            $error("IF/ID registers changed under stall");
            error_count++;
        end

    reset_pc: assert property (@(posedge clk) $rose(rst_n) |-> pc == `RESET_PC)
        else begin
            $error("pc left reset at %h", pc);
            error_count++;
        end

endmodule

bind riscv_if riscv_if_sva u_sva (.*);

// ==== test/riscv_if_tb.sv ====
`timescale 1ns/100ps
`include "riscv_if_macros.svh"

module riscv_if_tb;
    import rv_isa_pkg::*;
    import fetch_pkg::*;

    localparam int MEM_WORDS   = 64;
    localparam int NUM_INST    = 22;
    // Reset, jump, branch and stall phases come on top of the stream
    localparam int CYCLE_LIMIT = 20 * NUM_INST + 200;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         stall;
    logic         flush;
    logic         load_use_hazard;
    pc_src_e      pc_src;
    rv_addr_t     pc_branch;
    rv_addr_t     pc_j;
    logic         icache_stall;
    rv_inst_t     icache_rdata;
    logic         icache_ren;
    logic         icache_wen;
    icache_addr_t icache_addr;
    rv_inst_t     icache_wdata;
    rv_inst_t     inst_ppl;
    rv_addr_t     pc_ppl;
    logic         compressed_ppl;
    rv_addr_t     pc;

    rv_inst_t     mem [0:MEM_WORDS-1];
    int           hp;
    logic [31:0]  lcg_state = 32'd78;
    int           cycles = 0;

    // Checker state
    rv_addr_t     exp_pc = `RESET_PC;
    rv_addr_t     exp_next;
    rv_inst_t     exp_inst;
    int           exp_len;
    int           n_checked = 0;
    logic         loaded_q = 1'b0;
    logic         flush_q = 1'b0;

    riscv_if uut (.*);

    always #10 clk = ~clk;

    // Cache answers in the same cycle and returns garbage while stalled
    assign icache_rdata = (icache_ren && !icache_stall) ?
                          (icache_addr < MEM_WORDS ? mem[icache_addr[5:0]]
                                                   : fill_word(icache_addr)) :
                          32'hdead_beef;

    // Cache stall about one cycle in four
    always @(posedge clk) begin
        icache_stall <= (lcg_next() & 16'h3) == 16'h0;
    end

    function automatic rv_inst_t fill_word(input icache_addr_t a);
        return {a[15:0] ^ {2'b00, a[29:16]}, ~a[15:0]};
    endfunction

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    // Program image is built one half-word at a time
    task automatic emit16(input rv_cinst_t h);
        if (hp[0]) begin
            mem[hp / 2][31:16] = h;
        end else begin
            mem[hp / 2][15:0] = h;
        end
        hp++;
    endtask

    task automatic emit32(input rv_inst_t w);
        emit16(w[15:0]);
        emit16(w[31:16]);
    endtask

    function automatic rv_cinst_t half_at(input rv_addr_t addr);
        rv_inst_t word;
        word = (addr[31:2] < MEM_WORDS) ? mem[addr[7:2]] : fill_word(addr[31:2]);
        return addr[1] ? word[31:16] : word[15:0];
    endfunction

    // Expansion table of the supported RVC subset
    function automatic rv_inst_t expand_ref(input rv_cinst_t c);
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [4:0]  rs1p;
        logic [4:0]  rdp;
        logic [31:0] imm;
        rv_inst_t    res;
        rd   = c[11:7];
        rs2  = c[6:2];
        rs1p = 5'd8 + c[9:7];
        rdp  = 5'd8 + c[4:2];
        imm  = {25'd0, c[5], c[12:10], c[6], 2'b00};
        res  = '0;
        case ({c[15:13], c[1:0]})
            5'b010_00: res = {imm[11:0], rs1p, 3'b010, rdp, LOAD};
            5'b110_00: res = {imm[11:5], rdp, rs1p, 3'b010, imm[4:0], STORE};
            5'b000_01: begin
                imm = {{26{c[12]}}, c[12], c[6:2]};
                res = {imm[11:0], rd, 3'b000, rd, OP_IMM};
            end
            5'b010_01: begin
                imm = {{26{c[12]}}, c[12], c[6:2]};
                res = {imm[11:0], 5'd0, 3'b000, rd, OP_IMM};
            end
            5'b101_01: begin
                imm = {{21{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
                res = {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, JAL};
            end
            5'b110_01: begin
                imm = {{24{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};
                res = {imm[12], imm[10:5], 5'd0, rs1p, 3'b000, imm[4:1], imm[11], BRANCH};
            end
            5'b100_10: begin
                // C.MV adds to x0 and C.ADD to rd
                if (rs2 != 5'd0) begin
                    res = {7'd0, rs2, (c[12] ? rd : 5'd0), 3'b000, rd, OP};
                end
            end
            default: res = '0;
        endcase
        return res;
    endfunction

    function automatic rv_inst_t expects(input rv_addr_t at, output int len,
                                         output rv_addr_t next_pc);
        rv_cinst_t lo;
        rv_inst_t  res;
        lo = half_at(at);
        if (lo[1:0] != 2'b11) begin
            len = 2;
            res = expand_ref(lo);
        end else begin
            len = 4;
            res = {half_at(at + 32'd2), lo};
        end
        next_pc = at + len;
        return res;
    endfunction

    task automatic check_inst(input string name, input rv_inst_t got, input rv_inst_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h at pc %h", name, got, exp, exp_pc);
            $display("SIMULATION FAILED");
            $fatal(1, "instruction mismatch");
        end
    endtask

    task automatic check_addr(input string name, input rv_addr_t got, input rv_addr_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h at pc %h", name, got, exp, exp_pc);
            $display("SIMULATION FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    // Compare each delivered instruction with the program image
    always @(posedge clk) begin
        // Write data of the unused cache port
        check_inst("icache_wdata", icache_wdata, 32'h0);
        if (loaded_q && flush_q) begin
            check_inst("inst_ppl", inst_ppl, NOP_INST);
            check_flag("compressed_ppl", compressed_ppl, 1'b0);
        end else if (loaded_q && (inst_ppl != NOP_INST || compressed_ppl)) begin
            exp_inst = expects(exp_pc, exp_len, exp_next);
            check_addr("pc_ppl", pc_ppl, exp_pc);
            check_inst("inst_ppl", inst_ppl, exp_inst);
            check_flag("compressed_ppl", compressed_ppl, exp_len == 2);
            exp_pc = exp_next;
            n_checked++;
        end
        // Redirect sampled at this edge applies to the next delivery
        if (!rst_n) begin
            exp_pc = `RESET_PC;
        end else if (pc_src == PC_JUMP) begin
            exp_pc = pc_j;
        end else if (pc_src == PC_BRANCH) begin
            exp_pc = pc_branch;
        end
        loaded_q = rst_n && !stall;
        flush_q  = flush;
    end

    always @(posedge clk) begin
        if (uut.u_sva.error_count != 0) begin
            $display("An assertion on the fetch outputs failed");
            $display("SIMULATION FAILED");
            $fatal(1, "assertion failure");
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout, the fetch stream stalled for %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    // Flush hides whatever was ready at the old pc
    task automatic redirect(input pc_src_e src, input rv_addr_t j_target,
                            input rv_addr_t b_target);
        int n_start;
        @(posedge clk);
        pc_src    <= src;
        pc_j      <= j_target;
        pc_branch <= b_target;
        flush     <= 1'b1;
        @(posedge clk);
        pc_src <= PC_SEQ;
        flush  <= 1'b0;
        n_start = n_checked;
        wait (n_checked >= n_start + 4);
    endtask

    initial begin
        int n_start;
        rst_n           = 1'b0;
        stall           = 1'b0;
        flush           = 1'b0;
        load_use_hazard = 1'b0;
        pc_src          = PC_SEQ;
        pc_branch       = '0;
        pc_j            = '0;
        icache_stall    = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(icache_addr_t'(i));
        end

        // Instructions at 6, 14, 26, 38 and 54 cross a word boundary
        // C.SLLI at byte 34 lies outside the supported subset
        hp = 0;
        emit32(32'h003100B3);
        emit16(16'h429D);
        emit32(32'h0082A303);
        emit16(16'h1475);
        emit16(16'h0001);
        emit32(32'h00712623);
        emit16(16'h4144);
        emit16(16'hC60C);
        emit16(16'h86BA);
        emit16(16'h97C6);
        emit32(32'h064A0A13);
        emit16(16'hA801);
        emit16(16'hDC65);
        emit16(16'h0506);
        emit16(16'h52FD);
        emit32(32'h405201B3);
        emit16(16'h0085);
        emit32(32'h12345537);
        emit32(32'h0083E333);
        emit16(16'h84AA);
        emit32(32'h00A00893);
        emit16(16'h0001);

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        wait (exp_pc >= 2 * hp);

        // Jump target wins over the branch target presented with it
        redirect(PC_JUMP, 32'd18, 32'd40);
        redirect(PC_BRANCH, 32'd44, 32'd26);

        @(posedge clk);
        stall           <= 1'b1;
        load_use_hazard <= 1'b1;
        repeat (6) @(posedge clk);
        stall <= 1'b0;
        flush <= 1'b1;
        @(posedge clk);
        flush           <= 1'b0;
        load_use_hazard <= 1'b0;
        n_start = n_checked;
        wait (n_checked >= n_start + 6);
        @(posedge clk);

        if (uut.u_sva.error_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("An assertion on the fetch outputs failed");
            $display("SIMULATION FAILED");
            $fatal(1, "assertion failure");
        end
    end

endmodule

// ==== filelist.f ====
+incdir+include
hw/rv_isa_pkg.sv
hw/fetch_pkg.sv
hw/fetch_ctrl.sv
hw/realigner.sv
hw/rvc_decompressor.sv
hw/riscv_if.sv
test/riscv_if_sva.sv
test/riscv_if_tb.sv

// ==== Bender.yml ====
package:
  name: riscv_if

sources:
  - include_dirs:
      - include
    files:
      - hw/rv_isa_pkg.sv
      - hw/fetch_pkg.sv
      - hw/fetch_ctrl.sv
      - hw/realigner.sv
      - hw/rvc_decompressor.sv
      - hw/riscv_if.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/riscv_if_sva.sv
      - test/riscv_if_tb.sv
